/* hdl/mcpu_pkg.sv */
package mcpu_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Opcodes of the supported subset
    localparam opcode_t OPC_RTYPE = 6'h00;
    localparam opcode_t OPC_ADDIU = 6'h09;
    localparam opcode_t OPC_LW    = 6'h23;
    localparam opcode_t OPC_SW    = 6'h2b;
    localparam opcode_t OPC_BEQ   = 6'h04;
    localparam opcode_t OPC_J     = 6'h02;

    // R-type function codes
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    // Next-PC source select
    localparam logic [1:0] PC_SRC_INC    = 2'd0;
    localparam logic [1:0] PC_SRC_BRANCH = 2'd1;
    localparam logic [1:0] PC_SRC_JUMP   = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        IC_ALU_R,
        IC_ADDIU,
        IC_LOAD,
        IC_STORE,
        IC_BRANCH,
        IC_JUMP,
        IC_ILLEGAL
    } instr_class_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_REL,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_MEM_REL,
        S_WB
    } state_e;

endpackage

/* hdl/mcpu_decoder.sv */
`timescale 1ns/1ps

module mcpu_decoder (
    input  mcpu_pkg::word_t        instr_i,
    output mcpu_pkg::reg_addr_t    rs_o,
    output mcpu_pkg::reg_addr_t    rt_o,
    output mcpu_pkg::reg_addr_t    rd_o,
    output logic [15:0]            imm_o,
    output logic [25:0]            target_o,
    output mcpu_pkg::instr_class_e instr_class_o,
    output mcpu_pkg::alu_op_e      alu_op_o
);

    mcpu_pkg::opcode_t opcode;
    mcpu_pkg::funct_t  funct;

    // Field split
    assign opcode   = instr_i[31:26];
    assign rs_o     = instr_i[25:21];
    assign rt_o     = instr_i[20:16];
    assign rd_o     = instr_i[15:11];
    assign imm_o    = instr_i[15:0];
    assign target_o = instr_i[25:0];
    assign funct    = instr_i[5:0];

    always_comb begin
        instr_class_o = mcpu_pkg::IC_ILLEGAL;
        alu_op_o      = mcpu_pkg::ALU_ADD;
        case (opcode)
            mcpu_pkg::OPC_RTYPE: begin
                instr_class_o = mcpu_pkg::IC_ALU_R;
                case (funct)
                    mcpu_pkg::FN_ADDU: alu_op_o = mcpu_pkg::ALU_ADD;
                    mcpu_pkg::FN_SUBU: alu_op_o = mcpu_pkg::ALU_SUB;
                    mcpu_pkg::FN_AND:  alu_op_o = mcpu_pkg::ALU_AND;
                    mcpu_pkg::FN_OR:   alu_op_o = mcpu_pkg::ALU_OR;
                    mcpu_pkg::FN_SLT:  alu_op_o = mcpu_pkg::ALU_SLT;
                    // Unknown funct falls back to a no-op
                    default:           instr_class_o = mcpu_pkg::IC_ILLEGAL;
                endcase
            end
            mcpu_pkg::OPC_ADDIU: instr_class_o = mcpu_pkg::IC_ADDIU;
            mcpu_pkg::OPC_LW:    instr_class_o = mcpu_pkg::IC_LOAD;
            mcpu_pkg::OPC_SW:    instr_class_o = mcpu_pkg::IC_STORE;
            mcpu_pkg::OPC_BEQ: begin
                instr_class_o = mcpu_pkg::IC_BRANCH;
                alu_op_o      = mcpu_pkg::ALU_SUB;
            end
            mcpu_pkg::OPC_J:     instr_class_o = mcpu_pkg::IC_JUMP;
            default:             instr_class_o = mcpu_pkg::IC_ILLEGAL;
        endcase
    end

endmodule

/* hdl/mcpu_controller.sv */
`timescale 1ns/1ps

module mcpu_controller (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  mcpu_pkg::instr_class_e instr_class_i,
    input  logic                   alu_zero_i,
    input  logic                   mem_ack_i,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output logic                   pc_we_o,
    output logic                   ir_we_o,
    output logic                   z_we_o,
    output logic                   dr_we_o,
    output logic                   rf_we_o,
    output logic [1:0]             pc_src_o,
    output logic                   alu_b_imm_o,
    output logic                   wb_from_mem_o,
    output logic                   wb_dst_rt_o,
    output logic                   addr_from_z_o
);

    mcpu_pkg::state_e state_q;
    mcpu_pkg::state_e state_d;
    logic             req_q;
    logic             req_d;
    logic             we_q;
    logic             we_d;

    // Request and write strobe are registered so they stay low in reset
    assign mem_req_o = req_q;
    assign mem_we_o  = we_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= mcpu_pkg::S_FETCH;
            req_q   <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
            we_q    <= we_d;
        end
    end

    //////////////////////////////
    // Next state and enables
    //////////////////////////////

    always_comb begin
        state_d       = state_q;
        req_d         = req_q;
        we_d          = we_q;
        pc_we_o       = 1'b0;
        ir_we_o       = 1'b0;
        z_we_o        = 1'b0;
        dr_we_o       = 1'b0;
        rf_we_o       = 1'b0;
        pc_src_o      = mcpu_pkg::PC_SRC_INC;
        alu_b_imm_o   = 1'b0;
        wb_from_mem_o = 1'b0;
        wb_dst_rt_o   = 1'b0;
        addr_from_z_o = 1'b0;
        case (state_q)
            mcpu_pkg::S_FETCH: begin
                if (!req_q) begin
                    req_d = 1'b1;
                end else if (mem_ack_i) begin
                    // Capture the instruction and drop req together
                    ir_we_o = 1'b1;
                    req_d   = 1'b0;
                    state_d = mcpu_pkg::S_FETCH_REL;
                end
            end
            mcpu_pkg::S_FETCH_REL: begin
                if (!mem_ack_i) begin
                    state_d = mcpu_pkg::S_DECODE;
                end
            end
            mcpu_pkg::S_DECODE: begin
                // PC+4 lands here, branch offsets are relative to it
                pc_we_o  = 1'b1;
                pc_src_o = mcpu_pkg::PC_SRC_INC;
                state_d  = mcpu_pkg::S_EXEC;
            end
            mcpu_pkg::S_EXEC: begin
                case (instr_class_i)
                    mcpu_pkg::IC_ALU_R: begin
                        z_we_o  = 1'b1;
                        state_d = mcpu_pkg::S_WB;
                    end
                    mcpu_pkg::IC_ADDIU: begin
                        z_we_o      = 1'b1;
                        alu_b_imm_o = 1'b1;
                        state_d     = mcpu_pkg::S_WB;
                    end
                    mcpu_pkg::IC_LOAD, mcpu_pkg::IC_STORE: begin
                        // Effective address into Z
                        z_we_o      = 1'b1;
                        alu_b_imm_o = 1'b1;
                        state_d     = mcpu_pkg::S_MEM;
                    end
                    mcpu_pkg::IC_BRANCH: begin
                        pc_we_o  = alu_zero_i;
                        pc_src_o = mcpu_pkg::PC_SRC_BRANCH;
                        state_d  = mcpu_pkg::S_FETCH;
                    end
                    mcpu_pkg::IC_JUMP: begin
                        pc_we_o  = 1'b1;
                        pc_src_o = mcpu_pkg::PC_SRC_JUMP;
                        state_d  = mcpu_pkg::S_FETCH;
                    end
                    default: state_d = mcpu_pkg::S_FETCH;
                endcase
            end
            mcpu_pkg::S_MEM: begin
                addr_from_z_o = 1'b1;
                if (!req_q) begin
                    req_d = 1'b1;
                    we_d  = (instr_class_i == mcpu_pkg::IC_STORE);
                end else if (mem_ack_i) begin
                    dr_we_o = (instr_class_i == mcpu_pkg::IC_LOAD);
                    req_d   = 1'b0;
                    we_d    = 1'b0;
                    state_d = mcpu_pkg::S_MEM_REL;
                end
            end
            mcpu_pkg::S_MEM_REL: begin
                addr_from_z_o = 1'b1;
                if (!mem_ack_i) begin
                    if (instr_class_i == mcpu_pkg::IC_LOAD) begin
                        state_d = mcpu_pkg::S_WB;
                    end else begin
                        state_d = mcpu_pkg::S_FETCH;
                    end
                end
            end
            mcpu_pkg::S_WB: begin
                rf_we_o       = 1'b1;
                wb_from_mem_o = (instr_class_i == mcpu_pkg::IC_LOAD);
                // Only R-type writes to rd
                wb_dst_rt_o   = (instr_class_i != mcpu_pkg::IC_ALU_R);
                state_d       = mcpu_pkg::S_FETCH;
            end
            default: state_d = mcpu_pkg::S_FETCH;
        endcase
    end

endmodule

/* hdl/mcpu_regfile.sv */
`timescale 1ns/1ps

module mcpu_regfile (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                we_i,
    input  mcpu_pkg::reg_addr_t raddr1_i,
    input  mcpu_pkg::reg_addr_t raddr2_i,
    input  mcpu_pkg::reg_addr_t waddr_i,
    input  mcpu_pkg::word_t     wdata_i,
    output mcpu_pkg::word_t     rdata1_o,
    output mcpu_pkg::word_t     rdata2_o
);

    mcpu_pkg::word_t regs_q [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            // Register 0 never takes a write
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads
    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

endmodule

/* hdl/mcpu_alu.sv */
`timescale 1ns/1ps

module mcpu_alu (
    input  mcpu_pkg::word_t   a_i,
    input  mcpu_pkg::word_t   b_i,
    input  mcpu_pkg::alu_op_e op_i,
    output mcpu_pkg::word_t   result_o,
    output logic              zero_o
);

    logic slt_bit;

    // Signed compare for slt
    assign slt_bit = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            mcpu_pkg::ALU_ADD: result_o = a_i + b_i;
            mcpu_pkg::ALU_SUB: result_o = a_i - b_i;
            mcpu_pkg::ALU_AND: result_o = a_i & b_i;
            mcpu_pkg::ALU_OR:  result_o = a_i | b_i;
            mcpu_pkg::ALU_SLT: result_o = {31'd0, slt_bit};
            default:           result_o = '0;
        endcase
    end

    // Used by beq after a subtract
    assign zero_o = (result_o == 32'd0);

endmodule

/* hdl/mcpu_datapath.sv */
`timescale 1ns/1ps

module mcpu_datapath #(
    parameter mcpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                pc_we_i,
    input  logic                ir_we_i,
    input  logic                z_we_i,
    input  logic                dr_we_i,
    input  logic                rf_we_i,
    input  logic [1:0]          pc_src_i,
    input  logic                alu_b_imm_i,
    input  logic                wb_from_mem_i,
    input  logic                wb_dst_rt_i,
    input  logic                addr_from_z_i,
    input  mcpu_pkg::alu_op_e   alu_op_i,
    input  mcpu_pkg::reg_addr_t rs_i,
    input  mcpu_pkg::reg_addr_t rt_i,
    input  mcpu_pkg::reg_addr_t rd_i,
    input  logic [15:0]         imm_i,
    input  logic [25:0]         target_i,
    input  mcpu_pkg::word_t     mem_rdata_i,
    output mcpu_pkg::word_t     instr_o,
    output logic                alu_zero_o,
    output mcpu_pkg::word_t     mem_addr_o,
    output mcpu_pkg::word_t     mem_wdata_o
);

    mcpu_pkg::word_t     pc_q;
    mcpu_pkg::word_t     ir_q;
    mcpu_pkg::word_t     z_q;
    mcpu_pkg::word_t     rdr_q;
    mcpu_pkg::word_t     sdr_q;
    mcpu_pkg::word_t     rs_data;
    mcpu_pkg::word_t     rt_data;
    mcpu_pkg::word_t     imm_ext;
    mcpu_pkg::word_t     alu_b;
    mcpu_pkg::word_t     alu_result;
    mcpu_pkg::word_t     pc_next;
    mcpu_pkg::word_t     wb_data;
    mcpu_pkg::reg_addr_t wb_addr;

    //////////////////////////////
    // PC and IR
    //////////////////////////////

    // Branch target is taken off the already incremented PC
    always_comb begin
        case (pc_src_i)
            mcpu_pkg::PC_SRC_BRANCH: pc_next = pc_q + {imm_ext[29:0], 2'b00};
            mcpu_pkg::PC_SRC_JUMP:   pc_next = {pc_q[31:28], target_i, 2'b00};
            default:                 pc_next = pc_q + 32'd4;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
            ir_q <= '0;
        end else begin
            if (pc_we_i) begin
                pc_q <= pc_next;
            end
            if (ir_we_i) begin
                ir_q <= mem_rdata_i;
            end
        end
    end

    assign instr_o = ir_q;

    // Z, load data and store data
    always_ff @(posedge clk_i) begin
        if (z_we_i) begin
            z_q   <= alu_result;
            sdr_q <= rt_data;
        end
        if (dr_we_i) begin
            rdr_q <= mem_rdata_i;
        end
    end

    //////////////////////////////
    // Execute and write-back
    //////////////////////////////

    assign imm_ext = {{16{imm_i[15]}}, imm_i};
    assign alu_b   = alu_b_imm_i ? imm_ext : rt_data;
    assign wb_data = wb_from_mem_i ? rdr_q : z_q;
    assign wb_addr = wb_dst_rt_i ? rt_i : rd_i;

    mcpu_regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (rf_we_i),
        .raddr1_i (rs_i),
        .raddr2_i (rt_i),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data),
        .rdata1_o (rs_data),
        .rdata2_o (rt_data)
    );

    mcpu_alu u_alu (
        .a_i      (rs_data),
        .b_i      (alu_b),
        .op_i     (alu_op_i),
        .result_o (alu_result),
        .zero_o   (alu_zero_o)
    );

    // PC for fetch, Z for loads and stores
    assign mem_addr_o  = addr_from_z_i ? z_q : pc_q;
    assign mem_wdata_o = sdr_q;

endmodule

/* hdl/mcpu_top.sv */
`timescale 1ns/1ps

module mcpu_top #(
    parameter mcpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    output logic            mem_req_o,
    output logic            mem_we_o,
    output mcpu_pkg::word_t mem_addr_o,
    output mcpu_pkg::word_t mem_wdata_o,
    input  mcpu_pkg::word_t mem_rdata_i,
    input  logic            mem_ack_i
);

    // Decoder outputs
    mcpu_pkg::word_t        instr;
    mcpu_pkg::reg_addr_t    rs;
    mcpu_pkg::reg_addr_t    rt;
    mcpu_pkg::reg_addr_t    rd;
    logic [15:0]            imm;
    logic [25:0]            target;
    mcpu_pkg::instr_class_e instr_class;
    mcpu_pkg::alu_op_e      alu_op;

    // Controller to datapath
    logic                   pc_we;
    logic                   ir_we;
    logic                   z_we;
    logic                   dr_we;
    logic                   rf_we;
    logic [1:0]             pc_src;
    logic                   alu_b_imm;
    logic                   wb_from_mem;
    logic                   wb_dst_rt;
    logic                   addr_from_z;
    logic                   alu_zero;

    mcpu_decoder u_decoder (
        .instr_i       (instr),
        .rs_o          (rs),
        .rt_o          (rt),
        .rd_o          (rd),
        .imm_o         (imm),
        .target_o      (target),
        .instr_class_o (instr_class),
        .alu_op_o      (alu_op)
    );

    mcpu_controller u_controller (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_class_i (instr_class),
        .alu_zero_i    (alu_zero),
        .mem_ack_i     (mem_ack_i),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .pc_we_o       (pc_we),
        .ir_we_o       (ir_we),
        .z_we_o        (z_we),
        .dr_we_o       (dr_we),
        .rf_we_o       (rf_we),
        .pc_src_o      (pc_src),
        .alu_b_imm_o   (alu_b_imm),
        .wb_from_mem_o (wb_from_mem),
        .wb_dst_rt_o   (wb_dst_rt),
        .addr_from_z_o (addr_from_z)
    );

    mcpu_datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .pc_we_i       (pc_we),
        .ir_we_i       (ir_we),
        .z_we_i        (z_we),
        .dr_we_i       (dr_we),
        .rf_we_i       (rf_we),
        .pc_src_i      (pc_src),
        .alu_b_imm_i   (alu_b_imm),
        .wb_from_mem_i (wb_from_mem),
        .wb_dst_rt_i   (wb_dst_rt),
        .addr_from_z_i (addr_from_z),
        .alu_op_i      (alu_op),
        .rs_i          (rs),
        .rt_i          (rt),
        .rd_i          (rd),
        .imm_i         (imm),
        .target_i      (target),
        .mem_rdata_i   (mem_rdata_i),
        .instr_o       (instr),
        .alu_zero_o    (alu_zero),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o)
    );

endmodule

/* testbench/mcpu_checker.sv */
`timescale 1ns/1ps

module mcpu_checker (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             mem_req_i,
    input  logic             mem_we_i,
    input  mcpu_pkg::word_t  mem_addr_i,
    input  mcpu_pkg::word_t  mem_wdata_i,
    input  logic             mem_ack_i,
    input  int               test_idx_i,
    input  logic [2:0]       exp_num_i,
    input  logic [3:0][31:0] exp_addr_i,
    input  logic [3:0][31:0] exp_data_i,
    input  logic             test_end_i,
    input  logic             timed_out_i,
    output logic             all_seen_o,
    output int               pass_cnt_o,
    output int               fail_cnt_o
);

    logic [2:0] seen_cnt = 3'd0;
    int         err_cnt = 0;
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    logic       ack_q = 1'b0;
    logic       req_q = 1'b0;

    assign all_seen_o = (seen_cnt == exp_num_i);
    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    // Stores are compared in program order
    task automatic compare_store();
        logic [1:0] idx;
        idx = seen_cnt[1:0];
        if (seen_cnt >= exp_num_i) begin
            $display("unexpected store of 0x%08h to address 0x%08h", mem_wdata_i, mem_addr_i);
            err_cnt++;
        end else begin
            if (mem_addr_i !== exp_addr_i[idx]) begin
                $display("[FAIL] mem_addr_o expected 0x%08h got 0x%08h",
                         exp_addr_i[idx], mem_addr_i);
                err_cnt++;
            end
            if (mem_wdata_i !== exp_data_i[idx]) begin
                $display("[FAIL] mem_wdata_o expected 0x%08h got 0x%08h",
                         exp_data_i[idx], mem_wdata_i);
                err_cnt++;
            end
            seen_cnt = seen_cnt + 3'd1;
        end
    endtask

    task automatic report_test();
        if (timed_out_i) begin
            $display("test %0d timed out with %0d of %0d stores seen",
                     test_idx_i, seen_cnt, exp_num_i);
            err_cnt++;
        end
        if (err_cnt == 0) begin
            pass_cnt++;
            $display("test %0d passed", test_idx_i);
        end else begin
            fail_cnt++;
            $display("test %0d failed with %0d errors", test_idx_i, err_cnt);
        end
        seen_cnt = 3'd0;
        err_cnt  = 0;
    endtask

    // Sampled on the falling edge, away from the rising edge updates
    always @(negedge clk_i) begin
        if (!arst_n_i && mem_req_i) begin
            $display("memory request is high while reset is asserted");
            err_cnt++;
        end
        if (mem_req_i && !req_q && mem_ack_i) begin
            $display("memory request raised again before acknowledge went low");
            err_cnt++;
        end
        if (mem_ack_i && !ack_q && mem_req_i && mem_we_i) begin
            compare_store();
        end
        ack_q = mem_ack_i;
        req_q = mem_req_i;
        if (test_end_i) begin
            report_test();
        end
    end

endmodule

/* testbench/tb_mcpu.sv */
`timescale 1ns/1ps

module tb_mcpu;

    localparam int NUM_TESTS = 5;
    localparam int MAX_WAIT  = 5000;
    localparam int DRAIN     = 40;

    // MIPS encodings
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic            clk = 1'b0;
    logic            arst_n = 1'b0;
    logic            mem_req;
    logic            mem_we;
    mcpu_pkg::word_t mem_addr;
    mcpu_pkg::word_t mem_wdata;
    mcpu_pkg::word_t mem_rdata = '0;
    logic            mem_ack = 1'b0;

    // 1 KiB memory model
    mcpu_pkg::word_t mem [256];
    logic            busy = 1'b0;
    int              wait_cnt = 0;

    // Test table
    string           test_name [NUM_TESTS];
    mcpu_pkg::word_t prog [NUM_TESTS][16];
    int              prog_len [NUM_TESTS];
    mcpu_pkg::word_t data_word [NUM_TESTS];
    logic [2:0]      exp_num_tab [NUM_TESTS];
    mcpu_pkg::word_t exp_addr_tab [NUM_TESTS][4];
    mcpu_pkg::word_t exp_data_tab [NUM_TESTS][4];
    int              n_entries = 0;

    // Checker side
    logic [2:0]       exp_num = 3'd0;
    logic [3:0][31:0] exp_addr = '0;
    logic [3:0][31:0] exp_data = '0;
    int               test_idx = 0;
    logic             test_end = 1'b0;
    logic             timed_out = 1'b0;
    logic             all_seen;
    int               pass_cnt;
    int               fail_cnt;

    initial begin
        forever #5 clk = ~clk;
    end

    mcpu_top mcpu_top_inst (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_ack_i   (mem_ack)
    );

    mcpu_checker mcpu_checker_inst (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ack_i   (mem_ack),
        .test_idx_i  (test_idx),
        .exp_num_i   (exp_num),
        .exp_addr_i  (exp_addr),
        .exp_data_i  (exp_data),
        .test_end_i  (test_end),
        .timed_out_i (timed_out),
        .all_seen_o  (all_seen),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    //////////////////////////////
    // Memory handshake responder
    //////////////////////////////

    always @(posedge clk) begin
        if (!arst_n) begin
            mem_ack <= 1'b0;
            busy    <= 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req && !busy) begin
            busy     <= 1'b1;
            wait_cnt <= $urandom_range(7, 0);
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy    <= 1'b0;
                mem_ack <= 1'b1;
                if (mem_we) begin
                    mem[mem_addr[9:2]] = mem_wdata;
                end else begin
                    mem_rdata <= mem[mem_addr[9:2]];
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    //////////////////////////////
    // Instruction encoding
    //////////////////////////////

    function automatic mcpu_pkg::word_t rtype(input logic [5:0] fn, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mcpu_pkg::word_t itype(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mcpu_pkg::word_t jump_to(input mcpu_pkg::word_t addr);
        return {6'h02, addr[27:2]};
    endfunction

    task automatic begin_entry(input string name, input mcpu_pkg::word_t data);
        test_name[n_entries]   = name;
        data_word[n_entries]   = data;
        prog_len[n_entries]    = 0;
        exp_num_tab[n_entries] = 3'd0;
        n_entries++;
    endtask

    task automatic emit(input mcpu_pkg::word_t instr);
        int e;
        e = n_entries - 1;
        prog[e][prog_len[e]] = instr;
        prog_len[e]++;
    endtask

    task automatic expect_store(input mcpu_pkg::word_t addr, input mcpu_pkg::word_t data);
        int e;
        e = n_entries - 1;
        exp_addr_tab[e][exp_num_tab[e]] = addr;
        exp_data_tab[e][exp_num_tab[e]] = data;
        exp_num_tab[e] = exp_num_tab[e] + 3'd1;
    endtask

    task automatic build_table();
        // addu, subu, and, slt and or on 0x7ff0 and -3
        begin_entry("rtype_arith", 32'h0000_0000);
        emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'h7ff0));
        emit(itype(OP_ADDIU, 5'd0, 5'd2, 16'hfffd));
        emit(rtype(FN_ADDU, 5'd1, 5'd2, 5'd3));
        emit(rtype(FN_SUBU, 5'd2, 5'd1, 5'd4));
        emit(rtype(FN_AND, 5'd1, 5'd2, 5'd5));
        emit(rtype(FN_SLT, 5'd2, 5'd1, 5'd7));
        emit(rtype(FN_OR, 5'd5, 5'd2, 5'd8));
        emit(rtype(FN_ADDU, 5'd8, 5'd7, 5'd9));
        emit(itype(OP_SW, 5'd0, 5'd3, 16'h0200));
        emit(itype(OP_SW, 5'd0, 5'd4, 16'h0204));
        emit(itype(OP_SW, 5'd0, 5'd5, 16'h0208));
        emit(itype(OP_SW, 5'd0, 5'd9, 16'h020c));
        emit(jump_to(32'h30));
        expect_store(32'h200, 32'h0000_7fed);
        expect_store(32'h204, 32'hffff_800d);
        expect_store(32'h208, 32'h0000_7ff0);
        expect_store(32'h20c, 32'hffff_fffe);

        begin_entry("sign_extend", 32'h0000_0000);
        emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'h0100));
        emit(itype(OP_ADDIU, 5'd1, 5'd2, 16'hfedd));
        emit(itype(OP_ADDIU, 5'd0, 5'd3, 16'h8000));
        emit(itype(OP_SW, 5'd0, 5'd2, 16'h0210));
        emit(itype(OP_SW, 5'd0, 5'd3, 16'h0214));
        emit(jump_to(32'h14));
        expect_store(32'h210, 32'hffff_ffdd);
        expect_store(32'h214, 32'hffff_8000);

        // Base 0x110 with negative and positive offsets
        begin_entry("load_store", 32'h1234_5678);
        emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'h0110));
        emit(itype(OP_LW, 5'd1, 5'd2, 16'hfff0));
        emit(itype(OP_ADDIU, 5'd2, 5'd3, 16'h0011));
        emit(itype(OP_SW, 5'd1, 5'd3, 16'hfffc));
        emit(itype(OP_SW, 5'd1, 5'd2, 16'h0100));
        emit(jump_to(32'h14));
        expect_store(32'h10c, 32'h1234_5689);
        expect_store(32'h210, 32'h1234_5678);

        // Markers 0xa1 and 0xb2 show the path taken
        begin_entry("branches", 32'h0000_0000);
        emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'd5));
        emit(itype(OP_ADDIU, 5'd0, 5'd2, 16'd5));
        emit(itype(OP_ADDIU, 5'd0, 5'd3, 16'd6));
        emit(itype(OP_ADDIU, 5'd0, 5'd4, 16'h00a1));
        emit(itype(OP_ADDIU, 5'd0, 5'd5, 16'h00b2));
        emit(itype(OP_BEQ, 5'd1, 5'd2, 16'd1));
        emit(itype(OP_SW, 5'd0, 5'd1, 16'h0220));
        emit(itype(OP_BEQ, 5'd1, 5'd3, 16'd1));
        emit(itype(OP_SW, 5'd0, 5'd5, 16'h0224));
        emit(itype(OP_SW, 5'd0, 5'd4, 16'h0228));
        emit(jump_to(32'h28));
        expect_store(32'h224, 32'h0000_00b2);
        expect_store(32'h228, 32'h0000_00a1);

        begin_entry("jump_zero", 32'h0000_0000);
        emit(itype(OP_ADDIU, 5'd0, 5'd1, 16'h0055));
        emit(jump_to(32'h0c));
        emit(itype(OP_SW, 5'd0, 5'd1, 16'h0230));
        emit(itype(OP_ADDIU, 5'd0, 5'd0, 16'h0077));
        emit(rtype(FN_ADDU, 5'd1, 5'd1, 5'd0));
        emit(itype(OP_SW, 5'd0, 5'd0, 16'h0234));
        emit(itype(OP_SW, 5'd0, 5'd1, 16'h0238));
        emit(jump_to(32'h1c));
        expect_store(32'h234, 32'h0000_0000);
        expect_store(32'h238, 32'h0000_0055);
    endtask

    task automatic load_memory(input int t);
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hbad0_0000 ^ (i * 4);
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            mem[i] = prog[t][i];
        end
        // Data word at 0x100
        mem[64] = data_word[t];
    endtask

    //////////////////////////////
    // Test loop
    //////////////////////////////

    initial begin
        int cycles;
        void'($urandom(32'h715c));
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            arst_n   <= 1'b0;
            test_idx <= t;
            exp_num  <= exp_num_tab[t];
            for (int k = 0; k < 4; k++) begin
                exp_addr[k] <= exp_addr_tab[t][k];
                exp_data[k] <= exp_data_tab[t][k];
            end
            $display("test %0d (%s) started", t, test_name[t]);
            load_memory(t);
            repeat (16) @(posedge clk);
            arst_n <= 1'b1;
            cycles = 0;
            while (!all_seen && cycles < MAX_WAIT) begin
                @(posedge clk);
                cycles++;
            end
            // Quiet period to catch stray stores
            repeat (DRAIN) @(posedge clk);
            test_end  <= 1'b1;
            timed_out <= (cycles >= MAX_WAIT);
            @(posedge clk);
            test_end  <= 1'b0;
            timed_out <= 1'b0;
        end
        @(posedge clk);
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/mcpu_pkg.sv
hdl/mcpu_decoder.sv
hdl/mcpu_controller.sv
hdl/mcpu_regfile.sv
hdl/mcpu_alu.sv
hdl/mcpu_datapath.sv
hdl/mcpu_top.sv
testbench/mcpu_checker.sv
testbench/tb_mcpu.sv

/* Makefile */
# Verilator build and run for the multicycle MIPS testbench

VERILATOR ?= verilator
TOP       ?= tb_mcpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
